// ==== bench/core_mem_checker.sv ====
`include "mem_cfg.svh"

module core_mem_checker
    import mem_pkg::*;
(
    input logic                  clock,
    input logic                  reset,
    input logic                  mem_read,
    input logic                  mem_write,
    input logic                  mem_ready,
    input logic [`MEM_ABITS-1:0] mem_addr,
    input logic [`MEM_XLEN-1:0]  mem_wdata,
    input logic                  data_cache_miss_stall,
    input logic                  write_enable_out,
    input cache_state_t          cache_state
);
    timeunit 1ns;
    timeprecision 100ps;

    bus_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(mem_read && mem_write))
        else $error("bus read and write strobes high together");

    // request held until the model answers
    bus_stable: assert property (@(posedge clock) disable iff (reset)
        (mem_read || mem_write) && !mem_ready |=>
            $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_read) && $stable(mem_write))
        else $error("bus request changed before mem_ready");

    // a stall in idle moves the controller to fill or write at the next edge
    stall_busy: assert property (@(posedge clock) disable iff (reset)
        data_cache_miss_stall |=> cache_state != cs_idle)
        else $error("stall seen while cache controller stays idle");

    reset_quiet: assert property (@(posedge clock) reset |-> !write_enable_out)
        else $error("write_enable_out high during reset");

endmodule

// ==== bench/core_mem_tb.sv ====
`include "mem_cfg.svh"

module core_mem_tb
    import mem_pkg::*;
    import cp0_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum {
        op_alu, op_link, op_mfc0, op_load, op_store, op_mmio,
        op_sys, op_ov, op_ri, op_mtc0, op_eret, op_irq
    } op_t;

    typedef struct {
        string       name;
        op_t         op;
        logic [63:0] addr;   // address, pc or cp0 register number
        logic [63:0] data;
        mem_size_t   size;
        logic        sgn;
        logic [63:0] exp;    // w_data, or epc_out for handler entries
        logic        chk_stall;
        logic        exp_stall;
    } entry_t;

    logic clock, reset;
    logic [63:0] alu_out, b_data, pc4, fetch_pc, id_pc, d_rdata, mem_rdata;
    logic [4:0]  w_regnum;
    logic        write_enable, load_signed, link_pc, mfc0, mtc0;
    mem_size_t   load_type, store_type;
    cp0_reg_t    cp0_rd;
    logic [2:0]  cp0_sel;
    logic        overflow, break_inst, syscall, id_reserved_inst, id_eret, d_valid;
    logic [7:0]  interrupt_sources;
    logic        mem_ready;
    logic [63:0] w_data, epc_out, mem_addr, mem_wdata;
    logic [4:0]  w_regnum_out;
    logic        write_enable_out, taken_handler, data_cache_miss_stall, mem_read, mem_write;

    entry_t      table_q[$];
    logic [63:0] shadow [logic [63:0]];  // testbench copy of stored lines
    int          errors;
    int          timeouts;
    int          strobes;

    core_mem UUT (.*);

    mem_bus_model u_bus (.*);

    bind core_mem core_mem_checker u_checker (
        .clock, .reset, .mem_read, .mem_write, .mem_ready, .mem_addr, .mem_wdata,
        .data_cache_miss_stall, .write_enable_out, .cache_state(u_dcache.state_q)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        if (mem_read || mem_write) strobes++;  // bus busy cycles
    end

    function automatic logic [63:0] pattern(input logic [63:0] a);
        return a ^ {a[31:0], a[63:32]} ^ 64'hc3a5_96f0_0f69_5a3c;
    endfunction

    function automatic logic [63:0] model_word(input logic [63:0] a);
        logic [63:0] line;
        line = {a[63:3], 3'b000};
        return shadow.exists(line) ? shadow[line] : pattern(line);
    endfunction

    function automatic int size_bytes(input mem_size_t s);
        case (s)
            size_byte: return 1;
            size_half: return 2;
            size_word: return 4;
            default:   return 8;
        endcase
    endfunction

    function automatic logic [63:0] load_expect(input logic [63:0] a, input mem_size_t s,
                                                input logic sgn);
        logic [63:0] w;
        logic [63:0] r;
        int          n;
        w = model_word(a);
        r = '0;
        n = size_bytes(s);
        for (int i = 0; i < n; i++) r[8*i +: 8] = w[8*(a[2:0]+i) +: 8];
        if (sgn && n < 8 && r[8*n-1]) begin
            for (int i = n; i < 8; i++) r[8*i +: 8] = 8'hff;  // sign fill
        end
        return r;
    endfunction

    task automatic model_store(input logic [63:0] a, input logic [63:0] d, input mem_size_t s);
        logic [63:0] w;
        w = model_word(a);
        for (int i = 0; i < size_bytes(s); i++) w[8*(a[2:0]+i) +: 8] = d[8*i +: 8];
        shadow[{a[63:3], 3'b000}] = w;
    endtask

    task automatic add(input string name, input op_t op, input logic [63:0] addr,
                       input logic [63:0] data, input mem_size_t size, input logic sgn,
                       input logic [63:0] exp, input logic chk_stall = 0,
                       input logic exp_stall = 0);
        entry_t e;
        e = '{name, op, addr, data, size, sgn, exp, chk_stall, exp_stall};
        table_q.push_back(e);
        if (op == op_store) model_store(addr, data, size);
    endtask

    task automatic build_table();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        a = 64'h1040;
        b = 64'h2088;
        c = 64'h3100;
        add("alu", op_alu, 0, 64'h0123_4567_89ab_cdef, size_none, 0, 64'h0123_4567_89ab_cdef);
        add("link_over_mfc0", op_link, 0, 64'h4000_0010, size_none, 0, 64'h4000_0010);
        add("ld_d_miss", op_load, a, 0, size_dword, 0, load_expect(a, size_dword, 0), 1, 1);
        add("ld_d_hit", op_load, a, 0, size_dword, 0, load_expect(a, size_dword, 0), 1, 0);
        // upper bytes of the pattern at a have their top bit set, so both extensions show
        add("ld_b5_s", op_load, a + 5, 0, size_byte, 1, load_expect(a + 5, size_byte, 1), 1, 0);
        add("ld_b7_u", op_load, a + 7, 0, size_byte, 0, load_expect(a + 7, size_byte, 0), 1, 0);
        add("ld_h6_s", op_load, a + 6, 0, size_half, 1, load_expect(a + 6, size_half, 1), 1, 0);
        add("ld_h4_u", op_load, a + 4, 0, size_half, 0, load_expect(a + 4, size_half, 0), 1, 0);
        add("ld_w4_s", op_load, a + 4, 0, size_word, 1, load_expect(a + 4, size_word, 1), 1, 0);
        add("ld_w4_u", op_load, a + 4, 0, size_word, 0, load_expect(a + 4, size_word, 0), 1, 0);
        // stores hit a line that was just loaded, so partial merges are exact
        add("st_fill", op_load, b, 0, size_dword, 0, load_expect(b, size_dword, 0));
        add("st_b5", op_store, b + 5, 64'hab, size_byte, 0, 0);
        add("ld_after_b", op_load, b, 0, size_dword, 0, load_expect(b, size_dword, 0));
        add("st_h2", op_store, b + 2, 64'h9ee1, size_half, 0, 0);
        add("ld_after_h", op_load, b, 0, size_word, 1, load_expect(b, size_word, 1));
        add("st_w4", op_store, b + 4, 64'h8000_7fff, size_word, 0, 0);
        add("ld_after_w", op_load, b, 0, size_dword, 0, load_expect(b, size_dword, 0));
        add("st_d_miss", op_store, c, 64'h1122_3344_5566_7788, size_dword, 0, 0);
        add("ld_after_d", op_load, c, 0, size_dword, 0, load_expect(c, size_dword, 0), 1, 1);
        add("mmio_ld", op_mmio, 64'h8000_0000, 64'hfeed_face_cafe_f00d, size_word, 0,
            64'hfeed_face_cafe_f00d);
        add("syscall", op_sys, 64'h40_0100, 0, size_none, 0, 64'h40_0100);
        add("cause_sys", op_mfc0, c0_cause, 0, size_none, 0, 64'(exc_sys) << 2);
        add("overflow", op_ov, 64'h40_0200, 0, size_none, 0, 64'h40_0200);
        add("cause_ov", op_mfc0, c0_cause, 0, size_none, 0, 64'(exc_ov) << 2);
        add("reserved", op_ri, 64'h40_0300, 0, size_none, 0, 64'h40_0300);
        add("cause_ri", op_mfc0, c0_cause, 0, size_none, 0, 64'(exc_ri) << 2);
        add("epc_ri", op_mfc0, c0_epc, 0, size_none, 0, 64'h40_0300);
        add("eret_exc", op_eret, 0, 0, size_none, 0, 0);
        add("status_exc", op_mfc0, c0_status, 0, size_none, 0, 64'h0);  // exl clear again
        add("status_wr", op_mtc0, c0_status, 64'hff01, size_none, 0, 0);  // im all, ie set
        add("irq", op_irq, 64'h40_0404, 64'h04, size_none, 0, 64'h40_0404);
        add("eret_irq", op_eret, 0, 0, size_none, 0, 0);
        add("status_rd", op_mfc0, c0_status, 0, size_none, 0, 64'hff01);  // exl clear
    endtask

    task automatic set_idle();
        alu_out = '0;
        b_data = '0;
        pc4 = '0;
        w_regnum = '0;
        write_enable = 1'b0;
        load_type = size_none;
        store_type = size_none;
        load_signed = 1'b0;
        link_pc = 1'b0;
        mfc0 = 1'b0;
        mtc0 = 1'b0;
        cp0_rd = c0_status;
        cp0_sel = '0;
        overflow = 1'b0;
        break_inst = 1'b0;
        syscall = 1'b0;
        fetch_pc = '0;
        id_pc = '0;
        id_reserved_inst = 1'b0;
        id_eret = 1'b0;
        interrupt_sources = '0;
        d_valid = 1'b0;
        d_rdata = '0;
    endtask

    task automatic drive(input entry_t e, input int idx);
        set_idle();
        w_regnum = idx[4:0];
        write_enable = e.op inside {op_alu, op_link, op_mfc0, op_load, op_mmio};
        case (e.op)
            op_alu:   alu_out = e.data;
            op_link: begin
                link_pc = 1'b1;
                mfc0 = 1'b1;  // link must win
                pc4 = e.data;
            end
            op_mfc0: begin
                mfc0 = 1'b1;
                cp0_rd = cp0_reg_t'(e.addr[4:0]);
                alu_out = 64'hdead_beef;
            end
            op_load: begin
                alu_out = e.addr;
                load_type = e.size;
                load_signed = e.sgn;
            end
            op_store: begin
                alu_out = e.addr;
                store_type = e.size;
                b_data = e.data;
            end
            op_mmio: begin
                alu_out = e.addr;
                load_type = e.size;
                d_valid = 1'b1;
                d_rdata = e.data;
            end
            op_sys: begin
                syscall = 1'b1;
                id_pc = e.addr;
            end
            op_ov: begin
                overflow = 1'b1;
                id_pc = e.addr;
            end
            op_ri: begin
                id_reserved_inst = 1'b1;
                id_pc = e.addr;
            end
            op_mtc0: begin
                mtc0 = 1'b1;
                cp0_rd = cp0_reg_t'(e.addr[4:0]);
                b_data = e.data;
            end
            op_eret:  id_eret = 1'b1;
            default: begin
                interrupt_sources = e.data[7:0];
                fetch_pc = e.addr;
                id_pc = 64'h0bad_0000;
            end
        endcase
    endtask

    task automatic check_data(input string name, input string what,
                              input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_load(input string name, input mem_size_t size,
                              input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s load expected %h actual %h", name, size.name(), exp, act);
        end
    endtask

    task automatic check_code(input string name, input exc_code_t exp, input exc_code_t act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s exc code expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic run_entry(input int idx);
        entry_t e;
        int     waited;
        int     strobes_before;
        logic   seen_stall;
        e = table_q[idx];
        waited = 0;
        seen_stall = 1'b0;
        drive(e, idx);
        strobes_before = strobes;
        #1;
        while (data_cache_miss_stall && waited < 100) begin
            seen_stall = 1'b1;
            @(negedge clock);
            #1;
            waited++;
        end
        if (data_cache_miss_stall) begin
            timeouts++;
            $display("timeout: %s still stalled after 100 cycles", e.name);
            return;
        end
        @(posedge clock);  // accepted here
        @(negedge clock);
        set_idle();
        @(posedge clock);
        @(negedge clock);
        check_data(e.name, "w_regnum_out", 64'(idx[4:0]), 64'(w_regnum_out));
        check_bit(e.name, "write_enable_out",
                  e.op inside {op_alu, op_link, op_mfc0, op_load, op_mmio}, write_enable_out);
        check_bit(e.name, "taken_handler", e.op inside {op_sys, op_ov, op_ri, op_irq},
                  taken_handler);
        case (e.op)
            op_load: begin
                check_load(e.name, e.size, e.exp, w_data);
                if (e.chk_stall) check_bit(e.name, "stall", e.exp_stall, seen_stall);
            end
            op_mmio: begin
                check_data(e.name, "w_data", e.exp, w_data);
                check_data(e.name, "bus strobes", 64'(strobes_before), 64'(strobes));
            end
            op_alu, op_link: check_data(e.name, "w_data", e.exp, w_data);
            op_mfc0: begin
                check_data(e.name, "w_data", e.exp, w_data);
                if (e.addr[4:0] == c0_cause) begin
                    check_code(e.name, exc_code_t'(e.exp[6:2]), exc_code_t'(w_data[6:2]));
                end
            end
            op_sys, op_ov, op_ri, op_irq: check_data(e.name, "epc_out", e.exp, epc_out);
            default: ;
        endcase
    endtask

    initial begin
        void'($urandom(32'h6aa6_11cf));
        errors = 0;
        timeouts = 0;
        strobes = 0;
        set_idle();
        reset = 1'b1;
        build_table();
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        foreach (table_q[i]) begin
            run_entry(i);
            if (timeouts != 0) break;
        end
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/mem_bus_model.sv ====
`include "mem_cfg.svh"

module mem_bus_model (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [`MEM_ABITS-1:0] mem_addr,
    input  logic [`MEM_XLEN-1:0]  mem_wdata,
    output logic [`MEM_XLEN-1:0]  mem_rdata,
    output logic                  mem_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`MEM_XLEN-1:0] written [logic [`MEM_ABITS-1:0]];  // only stored lines
    logic                 busy;
    int                   wait_cnt;

    // untouched memory holds a value built from every address bit
    function automatic logic [`MEM_XLEN-1:0] fill_pattern(input logic [`MEM_ABITS-1:0] a);
        return a ^ {a[31:0], a[63:32]} ^ 64'hc3a5_96f0_0f69_5a3c;
    endfunction

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            busy      <= 1'b0;
            wait_cnt  <= 0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;  // one cycle pulse, cache leaves fill/write here
            busy      <= 1'b0;
        end else if ((mem_read || mem_write) && !busy) begin
            busy     <= 1'b1;
            wait_cnt <= $urandom_range(1, 4);
        end else if (busy) begin
            if (wait_cnt > 1) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                mem_ready <= 1'b1;
                if (mem_write) begin
                    written[mem_addr] = mem_wdata;
                end else if (written.exists(mem_addr)) begin
                    mem_rdata <= written[mem_addr];
                end else begin
                    mem_rdata <= fill_pattern(mem_addr);
                end
            end
        end
    end

endmodule

// ==== hdl/cache_l1.sv ====
`include "mem_cfg.svh"

module cache_l1
    import mem_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  signed_type,
    input  logic [`MEM_ABITS-1:0] addr,
    input  logic [`MEM_XLEN-1:0]  wdata,
    input  mem_size_t             mem_load_type,
    input  mem_size_t             mem_store_type,
    input  logic [`MEM_XLEN-1:0]  mem_rdata,
    input  logic                  mem_ready,
    output logic [`MEM_XLEN-1:0]  rdata,
    output logic                  miss,
    output logic [`MEM_ABITS-1:0] mem_addr,
    output logic [`MEM_XLEN-1:0]  mem_wdata,
    output logic                  mem_read,
    output logic                  mem_write
);

    localparam int offset_bits = $clog2(`MEM_XLEN / 8);
    localparam int index_bits  = `MEM_INDEX_BITS;
    localparam int tag_bits    = `MEM_ABITS - index_bits - offset_bits;
    localparam int lines       = 1 << index_bits;

    logic [tag_bits-1:0]   tag_mem  [lines];
    logic [`MEM_XLEN-1:0]  data_mem [lines];
    logic [lines-1:0]      valid_q;

    cache_state_t          state_q;
    cache_state_t          state_d;
    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;
    logic [offset_bits-1:0] offset;
    logic [`MEM_ABITS-1:0] line_addr;
    logic [`MEM_XLEN-1:0]  line_word;
    logic [`MEM_XLEN-1:0]  merged;
    logic                  hit;
    logic                  is_load;
    logic                  is_store;

    // pick the addressed bytes and extend them to full width
    function automatic logic [`MEM_XLEN-1:0] load_extract(
        input logic [`MEM_XLEN-1:0]  word,
        input logic [offset_bits-1:0] ofs,
        input mem_size_t             size,
        input logic                  sign_ext
    );
        logic [`MEM_XLEN-1:0] shifted;
        logic [`MEM_XLEN-1:0] result;
        shifted = word >> {ofs, 3'b000};
        case (size)
            size_byte: result = {{(`MEM_XLEN-8){sign_ext & shifted[7]}}, shifted[7:0]};
            size_half: result = {{(`MEM_XLEN-16){sign_ext & shifted[15]}}, shifted[15:0]};
            size_word: result = {{(`MEM_XLEN-32){sign_ext & shifted[31]}}, shifted[31:0]};
            default:   result = shifted;
        endcase
        return result;
    endfunction

    // low bytes of the store data land at the byte offset
    function automatic logic [`MEM_XLEN-1:0] store_merge(
        input logic [`MEM_XLEN-1:0]  old_word,
        input logic [`MEM_XLEN-1:0]  data,
        input logic [offset_bits-1:0] ofs,
        input mem_size_t             size
    );
        logic [`MEM_XLEN-1:0] mask;
        case (size)
            size_byte: mask = `MEM_XLEN'(8'hff);
            size_half: mask = `MEM_XLEN'(16'hffff);
            size_word: mask = `MEM_XLEN'(32'hffff_ffff);
            default:   mask = '1;
        endcase
        mask = mask << {ofs, 3'b000};
        return (old_word & ~mask) | ((data << {ofs, 3'b000}) & mask);
    endfunction

    assign index     = addr[offset_bits +: index_bits];
    assign tag       = addr[`MEM_ABITS-1 -: tag_bits];
    assign offset    = addr[offset_bits-1:0];
    assign line_addr = {addr[`MEM_ABITS-1:offset_bits], {offset_bits{1'b0}}};
    assign line_word = data_mem[index];
    assign hit       = valid_q[index] && (tag_mem[index] == tag);
    assign is_load   = mem_load_type != size_none;
    assign is_store  = mem_store_type != size_none;

    // no byte enables on the bus, a partial store that misses sends zeros
    // in the bytes it does not cover
    assign merged = store_merge(hit ? line_word : '0, wdata, offset, mem_store_type);

    always_comb begin
        state_d = state_q;
        miss    = 1'b0;
        case (state_q)
            cs_idle: begin
                if (is_store) begin
                    miss    = 1'b1;  // write-through, always goes to the bus
                    state_d = cs_write;
                end else if (is_load && !hit) begin
                    miss    = 1'b1;
                    state_d = cs_fill;
                end
            end
            cs_fill, cs_write: begin
                miss = 1'b1;
                if (mem_ready) begin
                    state_d = cs_idle;
                end
            end
            default: state_d = cs_idle;
        endcase
    end

    assign mem_read  = state_q == cs_fill;
    assign mem_write = state_q == cs_write;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state_q <= cs_idle;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == cs_fill && mem_ready) begin
                valid_q[index] <= 1'b1;
            end
        end
    end

    // arrays, read data and bus payload
    always_ff @(posedge clock) begin
        case (state_q)
            cs_idle: begin
                if (is_store) begin
                    mem_addr  <= line_addr;
                    mem_wdata <= merged;
                    if (hit) begin
                        data_mem[index] <= merged;
                    end
                end else if (is_load) begin
                    if (hit) begin
                        rdata <= load_extract(line_word, offset, mem_load_type, signed_type);
                    end else begin
                        mem_addr <= line_addr;
                    end
                end
            end
            cs_fill: begin
                if (mem_ready) begin
                    tag_mem[index]  <= tag;
                    data_mem[index] <= mem_rdata;
                    rdata <= load_extract(mem_rdata, offset, mem_load_type, signed_type);
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/core_mem.sv ====
`include "mem_cfg.svh"

module core_mem
    import mem_pkg::*;
    import cp0_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`MEM_XLEN-1:0]  alu_out,
    input  logic [`MEM_XLEN-1:0]  b_data,
    input  logic [`MEM_XLEN-1:0]  pc4,
    input  logic [4:0]            w_regnum,
    input  logic                  write_enable,
    input  mem_size_t             load_type,
    input  mem_size_t             store_type,
    input  logic                  load_signed,
    input  logic                  link_pc,
    input  logic                  mfc0,
    input  logic                  mtc0,
    input  cp0_reg_t              cp0_rd,
    input  logic [2:0]            cp0_sel,
    input  logic                  overflow,
    input  logic                  break_inst,
    input  logic                  syscall,
    input  logic [`MEM_XLEN-1:0]  fetch_pc,
    input  logic [`MEM_XLEN-1:0]  id_pc,
    input  logic                  id_reserved_inst,
    input  logic                  id_eret,
    input  logic [7:0]            interrupt_sources,
    input  logic                  d_valid,
    input  logic [`MEM_XLEN-1:0]  d_rdata,
    input  logic [`MEM_XLEN-1:0]  mem_rdata,
    input  logic                  mem_ready,
    output logic [`MEM_XLEN-1:0]  w_data,
    output logic [4:0]            w_regnum_out,
    output logic                  write_enable_out,
    output logic [`MEM_XLEN-1:0]  epc_out,
    output logic                  taken_handler,
    output logic                  data_cache_miss_stall,
    output logic [`MEM_ABITS-1:0] mem_addr,
    output logic [`MEM_XLEN-1:0]  mem_wdata,
    output logic                  mem_read,
    output logic                  mem_write
);

    logic [`MEM_XLEN-1:0] c0_rd_data;
    logic [`MEM_XLEN-1:0] c0_epc;
    logic [`MEM_XLEN-1:0] cache_rdata;
    logic [`MEM_XLEN-1:0] wb_data;
    logic                 c0_taken;
    logic                 cache_miss;
    mem_size_t            cache_load_type;
    mem_size_t            cache_store_type;

    // first stage registers
    logic [`MEM_XLEN-1:0] m1_alu_out;
    logic [`MEM_XLEN-1:0] m1_pc4;
    logic [`MEM_XLEN-1:0] m1_c0_rd_data;
    logic [`MEM_XLEN-1:0] m1_epc;
    logic [`MEM_XLEN-1:0] m1_d_rdata;
    logic [4:0]           m1_w_regnum;
    logic                 m1_write_enable;
    logic                 m1_taken_handler;
    logic                 m1_is_load;
    logic                 m1_mmio;
    logic                 m1_link_pc;
    logic                 m1_mfc0;

    cp0 u_cp0 (
        .clock            (clock),
        .reset            (reset),
        .wr_data          (b_data),
        .regnum           (cp0_rd),
        .sel              (cp0_sel),
        .if_pc            (fetch_pc),
        .curr_pc          (id_pc),
        .mtc0             (mtc0),
        .eret             (id_eret),
        .interrupt_source (interrupt_sources),
        .overflow         (overflow),
        .reserved_inst    (id_reserved_inst),
        .break_inst       (break_inst),
        .syscall          (syscall),
        .rd_data          (c0_rd_data),
        .epc              (c0_epc),
        .taken_handler    (c0_taken)
    );

    // peripheral accesses keep the size but must not touch the cache
    assign cache_load_type  = d_valid ? size_none : load_type;
    assign cache_store_type = d_valid ? size_none : store_type;

    cache_l1 u_dcache (
        .clock          (clock),
        .reset          (reset),
        .signed_type    (load_signed),
        .addr           (alu_out),
        .wdata          (b_data),
        .mem_load_type  (cache_load_type),
        .mem_store_type (cache_store_type),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready),
        .rdata          (cache_rdata),
        .miss           (cache_miss),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_read       (mem_read),
        .mem_write      (mem_write)
    );

    assign data_cache_miss_stall = cache_miss & ~mem_ready;

    // write-back source, link pc highest
    always_comb begin
        if (m1_link_pc) begin
            wb_data = m1_pc4;
        end else if (m1_mfc0) begin
            wb_data = m1_c0_rd_data;
        end else if (m1_mmio) begin
            wb_data = m1_d_rdata;
        end else if (m1_is_load) begin
            wb_data = cache_rdata;  // registered by the cache at acceptance
        end else begin
            wb_data = m1_alu_out;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            m1_w_regnum      <= '0;
            m1_write_enable  <= 1'b0;
            m1_taken_handler <= 1'b0;
            m1_is_load       <= 1'b0;
            m1_mmio          <= 1'b0;
            m1_link_pc       <= 1'b0;
            m1_mfc0          <= 1'b0;
            w_regnum_out     <= '0;
            write_enable_out <= 1'b0;
            taken_handler    <= 1'b0;
        end else begin
            m1_w_regnum      <= w_regnum;
            m1_write_enable  <= write_enable;
            m1_taken_handler <= c0_taken;
            m1_is_load       <= load_type != size_none;
            m1_mmio          <= d_valid;
            m1_link_pc       <= link_pc;
            m1_mfc0          <= mfc0;
            w_regnum_out     <= m1_w_regnum;
            write_enable_out <= m1_write_enable;
            taken_handler    <= m1_taken_handler;
        end
    end

    always_ff @(posedge clock) begin
        m1_alu_out    <= alu_out;
        m1_pc4        <= pc4;
        m1_c0_rd_data <= c0_rd_data;
        m1_epc        <= c0_epc;
        m1_d_rdata    <= d_rdata;  // peripheral answers in the access cycle
        w_data        <= wb_data;
        epc_out       <= m1_epc;
    end

endmodule

// ==== hdl/cp0.sv ====
`include "mem_cfg.svh"

module cp0
    import cp0_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [`MEM_XLEN-1:0] wr_data,
    input  cp0_reg_t             regnum,
    input  logic [2:0]           sel,
    input  logic [`MEM_XLEN-1:0] if_pc,
    input  logic [`MEM_XLEN-1:0] curr_pc,
    input  logic                 mtc0,
    input  logic                 eret,
    input  logic [7:0]           interrupt_source,
    input  logic                 overflow,
    input  logic                 reserved_inst,
    input  logic                 break_inst,
    input  logic                 syscall,
    output logic [`MEM_XLEN-1:0] rd_data,
    output logic [`MEM_XLEN-1:0] epc,
    output logic                 taken_handler
);

    logic [`MEM_XLEN-1:0] status_q;  // [0] ie, [1] exl, [15:8] im
    logic [`MEM_XLEN-1:0] cause_q;   // [15:8] pending, [6:2] code
    logic [`MEM_XLEN-1:0] epc_q;
    logic                 exception;
    logic                 interrupt;
    exc_code_t            exc_code;

    assign exception = overflow | reserved_inst | break_inst | syscall;

    // interrupts only while enabled and not already in a handler
    assign interrupt = (|(interrupt_source & status_q[15:8])) & status_q[0] & ~status_q[1];

    assign taken_handler = exception | interrupt;  // exceptions win, see exc_code

    // later assignments override, so the last one has top priority
    always_comb begin
        exc_code = exc_int;
        if (break_inst) begin
            exc_code = exc_bp;
        end
        if (syscall) begin
            exc_code = exc_sys;
        end
        if (overflow) begin
            exc_code = exc_ov;
        end
        if (reserved_inst) begin
            exc_code = exc_ri;
        end
    end

    // next epc is visible in the same cycle so the pipeline can register it
    always_comb begin
        if (exception) begin
            epc = curr_pc;
        end else if (interrupt) begin
            epc = if_pc;  // resume at the instruction not yet executed
        end else begin
            epc = epc_q;
        end
    end

    always_comb begin
        rd_data = '0;
        if (sel == 3'd0) begin
            case (regnum)
                c0_status: rd_data = status_q;
                c0_cause:  rd_data = cause_q;
                c0_epc:    rd_data = epc_q;
                default:   rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            status_q <= '0;
            cause_q  <= '0;
            epc_q    <= '0;
        end else begin
            cause_q[15:8] <= interrupt_source;  // raw pending lines
            if (mtc0 && sel == 3'd0) begin
                case (regnum)
                    c0_status: status_q <= wr_data;
                    c0_cause:  cause_q[6:2] <= wr_data[6:2];
                    c0_epc:    epc_q <= wr_data;
                    default:   ;
                endcase
            end
            if (eret) begin
                status_q[1] <= 1'b0;
            end
            // handler entry overrides a software write in the same cycle
            if (taken_handler) begin
                status_q[1]  <= 1'b1;
                cause_q[6:2] <= exc_code;
                epc_q        <= epc;
            end
        end
    end

endmodule

// ==== hdl/cp0_pkg.sv ====
package cp0_pkg;

    // coprocessor-0 register numbers (rd field of mfc0/mtc0)
    typedef enum logic [4:0] {
        c0_status = 5'd12,
        c0_cause  = 5'd13,
        c0_epc    = 5'd14
    } cp0_reg_t;

    // exception codes, kept in cause[6:2]
    typedef enum logic [4:0] {
        exc_int = 5'd0,   // external interrupt
        exc_sys = 5'd8,   // syscall
        exc_bp  = 5'd9,   // break
        exc_ri  = 5'd10,  // reserved instruction
        exc_ov  = 5'd12   // arithmetic overflow
    } exc_code_t;

endpackage

// ==== hdl/mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// register and PC width
`define MEM_XLEN 64

// byte address width on the memory bus
`define MEM_ABITS 64

// direct-mapped index width, 2**n lines of one doubleword each
`define MEM_INDEX_BITS 6

// the cache derives its offset from the word width, so a line is
// always exactly one data word and tag width follows from these three

`endif

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    // width of a load or store, size_none means no access this cycle
    typedef enum logic [2:0] {
        size_none  = 3'd0,
        size_byte  = 3'd1,
        size_half  = 3'd2,
        size_word  = 3'd3,
        size_dword = 3'd4
    } mem_size_t;

    // data cache controller
    //   cs_idle  : lookups, hits answered in one cycle
    //   cs_fill  : bus read outstanding for a load miss
    //   cs_write : bus write outstanding, every store passes here
    typedef enum logic [1:0] {
        cs_idle  = 2'd0,
        cs_fill  = 2'd1,
        cs_write = 2'd2
    } cache_state_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module core_mem_tb -f tb.f --Mdir obj_dir -o core_mem_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/core_mem_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1

// ==== tb.f ====
+incdir+hdl
hdl/mem_pkg.sv
hdl/cp0_pkg.sv
hdl/cp0.sv
hdl/cache_l1.sv
hdl/core_mem.sv
bench/mem_bus_model.sv
bench/core_mem_checker.sv
bench/core_mem_tb.sv
